// ==== rtl/bus_pkg.sv ====
// Data bus definitions; 32-bit words only, byte lanes little endian
package bus_pkg;

  localparam int bus_addr_w = 32;
  localparam int bus_data_w = 32;
  localparam int bus_be_w   = bus_data_w / 8;

  // One bus address, seen either as a word index or as page plus register index
  typedef union packed {
    // Used by memories
    struct packed {
      logic [29:0] index;
      logic [1:0]  offset;
    } word;
    // Used by register blocks with 4 KiB pages
    struct packed {
      logic [19:0] page;
      logic [9:0]  index;
      logic [1:0]  offset;
    } regs;
  } bus_addr_u;

endpackage

// ==== rtl/soc_map_pkg.sv ====
// Address map of demo_soc; every region is a power-of-two size, aligned to its own size
package soc_map_pkg;

  // Device index, also the slot in the decoder's request and response vectors
  typedef enum logic [1:0] {
    dev_ram   = 2'd0,
    dev_gpio  = 2'd1,
    dev_timer = 2'd2
  } soc_device_e;

  localparam int nr_devices = 3;

  // 64 KiB of RAM
  localparam logic [31:0] ram_base   = 32'h0010_0000;
  localparam logic [31:0] ram_mask   = ~32'h0000_FFFF;

  // 4 KiB each for the register devices
  localparam logic [31:0] gpio_base  = 32'h8000_0000;
  localparam logic [31:0] gpio_mask  = ~32'h0000_0FFF;
  localparam logic [31:0] timer_base = 32'h8000_2000;
  localparam logic [31:0] timer_mask = ~32'h0000_0FFF;

  // GPIO register indexes, in words
  localparam logic [9:0] gpio_out_reg = 10'd0;
  localparam logic [9:0] gpio_in_reg  = 10'd1;

  // Timer register indexes, in words
  localparam logic [9:0] timer_mtime_lo_reg = 10'd0;
  localparam logic [9:0] timer_mtime_hi_reg = 10'd1;
  localparam logic [9:0] timer_cmp_lo_reg   = 10'd2;
  localparam logic [9:0] timer_cmp_hi_reg   = 10'd3;

endpackage

// ==== rtl/bus_decoder.sv ====
// Single-host decoder; no back-pressure, unmapped addresses answer with an error one cycle later
`timescale 1ns/1ps

module bus_decoder (
  input  logic                                clk_sys_i,
  input  logic                                rst_sys_ni,

  input  logic                                host_req_i,
  input  logic                                host_we_i,
  input  logic [bus_pkg::bus_be_w-1:0]        host_be_i,
  input  logic [bus_pkg::bus_addr_w-1:0]      host_addr_i,
  input  logic [bus_pkg::bus_data_w-1:0]      host_wdata_i,
  output logic                                host_rvalid_o,
  output logic [bus_pkg::bus_data_w-1:0]      host_rdata_o,
  output logic                                host_err_o,

  output logic [soc_map_pkg::nr_devices-1:0]  dev_req_o,
  output logic                                dev_we_o,
  output logic [bus_pkg::bus_be_w-1:0]        dev_be_o,
  output bus_pkg::bus_addr_u                  dev_addr_o,
  output logic [bus_pkg::bus_data_w-1:0]      dev_wdata_o,
  input  logic [soc_map_pkg::nr_devices-1:0]  dev_rvalid_i,
  input  logic [bus_pkg::bus_data_w-1:0]      dev_rdata_i [soc_map_pkg::nr_devices]
);
  import bus_pkg::*;
  import soc_map_pkg::*;

  localparam logic [bus_addr_w-1:0] dev_base [nr_devices] = '{
    dev_ram:   ram_base,
    dev_gpio:  gpio_base,
    dev_timer: timer_base
  };
  localparam logic [bus_addr_w-1:0] dev_mask [nr_devices] = '{
    dev_ram:   ram_mask,
    dev_gpio:  gpio_mask,
    dev_timer: timer_mask
  };

  logic [nr_devices-1:0] dev_sel;
  soc_device_e           sel_dev;
  logic                  unmapped;
  soc_device_e           rsp_dev_q; // Device that owns the pending response
  logic                  err_q;

  always_comb begin
    dev_sel = '0;
    sel_dev = dev_ram;
    for (int i = 0; i < nr_devices; i++) begin
      if ((host_addr_i & dev_mask[i]) == dev_base[i]) begin
        dev_sel[i] = 1'b1;
        sel_dev    = soc_device_e'(i);
      end
    end
  end

  assign unmapped  = host_req_i & ~|dev_sel;
  assign dev_req_o = host_req_i ? dev_sel : '0;

  // Request fields go to every device, only dev_req_o qualifies them
  assign dev_we_o    = host_we_i;
  assign dev_be_o    = host_be_i;
  assign dev_addr_o  = host_addr_i;
  assign dev_wdata_o = host_wdata_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rsp_dev_q <= dev_ram;
      err_q     <= 1'b0;
    end else begin
      err_q <= unmapped;
      if (host_req_i && !unmapped) begin
        rsp_dev_q <= sel_dev;
      end
    end
  end

  always_comb begin
    host_rdata_o = '0; // Zero on error responses
    if (dev_rvalid_i[rsp_dev_q]) begin
      host_rdata_o = dev_rdata_i[rsp_dev_q];
    end
  end

  assign host_rvalid_o = |dev_rvalid_i | err_q;
  assign host_err_o    = err_q;

  // Regions in soc_map_pkg must not overlap
  a_sel_onehot0 : assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $onehot0(dev_sel));

  // Devices answer only to a request from the cycle before
  a_rvalid_after_req : assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_rvalid_o |-> $past(host_req_i));

endmodule

// ==== rtl/ram_1p.sv ====
// Single-port RAM; mem_depth must be a power of two, contents are not initialised
`timescale 1ns/1ps

module ram_1p #(
  parameter int mem_depth = 16384
) (
  input  logic                           clk_sys_i,
  input  logic                           rst_sys_ni,

  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [bus_pkg::bus_be_w-1:0]   be_i,
  input  bus_pkg::bus_addr_u             addr_i,
  input  logic [bus_pkg::bus_data_w-1:0] wdata_i,
  output logic                           rvalid_o,
  output logic [bus_pkg::bus_data_w-1:0] rdata_o
);
  import bus_pkg::*;
  import soc_map_pkg::*;

  localparam int          idx_w    = $clog2(mem_depth);
  localparam logic [29:0] base_idx = ram_base[31:2];

  logic [bus_data_w-1:0] mem [mem_depth];
  logic [idx_w-1:0]      word_idx;

  assign word_idx = addr_i.word.index[idx_w-1:0]; // Region base bits dropped

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < bus_be_w; b++) begin
          if (be_i[b]) begin
            mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      rdata_o <= mem[word_idx]; // Old data on a write
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  // The decoded RAM window has to fit in the array, or words would alias
  a_idx_in_range : assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    req_i |-> ((addr_i.word.index - base_idx) < mem_depth));

endmodule

// ==== rtl/gpio_regs.sv ====
// GPIO registers; gpi_width and gpo_width at most 32, gp_i is asynchronous and synchronised here
`timescale 1ns/1ps

module gpio_regs #(
  parameter int gpi_width = 8,
  parameter int gpo_width = 16
) (
  input  logic                           clk_sys_i,
  input  logic                           rst_sys_ni,

  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [bus_pkg::bus_be_w-1:0]   be_i,
  input  bus_pkg::bus_addr_u             addr_i,
  input  logic [bus_pkg::bus_data_w-1:0] wdata_i,
  output logic                           rvalid_o,
  output logic [bus_pkg::bus_data_w-1:0] rdata_o,

  input  logic [gpi_width-1:0]           gp_i,
  output logic [gpo_width-1:0]           gp_o
);
  import bus_pkg::*;
  import soc_map_pkg::*;

  logic [gpo_width-1:0]  gpo_q;
  logic [gpi_width-1:0]  gpi_meta_q;
  logic [gpi_width-1:0]  gpi_sync_q;
  logic [bus_data_w-1:0] gpo_wr;
  logic [bus_data_w-1:0] rd_mux;

  // Merge written byte lanes into the current outputs
  always_comb begin
    gpo_wr = bus_data_w'(gpo_q);
    for (int b = 0; b < bus_be_w; b++) begin
      if (be_i[b]) begin
        gpo_wr[8*b +: 8] = wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      rvalid_o   <= 1'b0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      rvalid_o   <= req_i;
      if (req_i && we_i && addr_i.regs.index == gpio_out_reg) begin
        gpo_q <= gpo_wr[gpo_width-1:0];
      end
    end
  end

  always_comb begin
    case (addr_i.regs.index)
      gpio_out_reg: rd_mux = bus_data_w'(gpo_q);
      gpio_in_reg:  rd_mux = bus_data_w'(gpi_sync_q);
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_o <= rd_mux;
    end
  end

  assign gp_o = gpo_q;

endmodule

// ==== rtl/timer_regs.sv ====
// Machine timer; mtime counts clk_sys_i cycles, irq follows the compare one cycle late
`timescale 1ns/1ps

module timer_regs (
  input  logic                           clk_sys_i,
  input  logic                           rst_sys_ni,

  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [bus_pkg::bus_be_w-1:0]   be_i,
  input  bus_pkg::bus_addr_u             addr_i,
  input  logic [bus_pkg::bus_data_w-1:0] wdata_i,
  output logic                           rvalid_o,
  output logic [bus_pkg::bus_data_w-1:0] rdata_o,

  output logic                           timer_irq_o
);
  import bus_pkg::*;
  import soc_map_pkg::*;

  logic [63:0]           mtime_q;
  logic [63:0]           mtime_d;
  logic [63:0]           cmp_q;
  logic [63:0]           cmp_d;
  logic                  irq_q;
  logic                  wr_en;
  logic [bus_data_w-1:0] rd_mux;

  function automatic logic [bus_data_w-1:0] be_merge(
    input logic [bus_data_w-1:0] old_val,
    input logic [bus_data_w-1:0] new_val,
    input logic [bus_be_w-1:0]   be
  );
    logic [bus_data_w-1:0] res;
    res = old_val;
    for (int b = 0; b < bus_be_w; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr_en = req_i & we_i;

  always_comb begin
    mtime_d = mtime_q + 64'd1;
    cmp_d   = cmp_q;
    if (wr_en) begin
      // A bus write wins over the increment for that cycle
      case (addr_i.regs.index)
        timer_mtime_lo_reg: mtime_d[31:0]  = be_merge(mtime_q[31:0], wdata_i, be_i);
        timer_mtime_hi_reg: mtime_d[63:32] = be_merge(mtime_q[63:32], wdata_i, be_i);
        timer_cmp_lo_reg:   cmp_d[31:0]    = be_merge(cmp_q[31:0], wdata_i, be_i);
        timer_cmp_hi_reg:   cmp_d[63:32]   = be_merge(cmp_q[63:32], wdata_i, be_i);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q  <= '0;
      cmp_q    <= '1; // Far future, irq stays low
      irq_q    <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      mtime_q  <= mtime_d;
      cmp_q    <= cmp_d;
      irq_q    <= (mtime_q >= cmp_q);
      rvalid_o <= req_i;
    end
  end

  always_comb begin
    case (addr_i.regs.index)
      timer_mtime_lo_reg: rd_mux = mtime_q[31:0];
      timer_mtime_hi_reg: rd_mux = mtime_q[63:32];
      timer_cmp_lo_reg:   rd_mux = cmp_q[31:0];
      timer_cmp_hi_reg:   rd_mux = cmp_q[63:32];
      default:            rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_o <= rd_mux;
    end
  end

  assign timer_irq_o = irq_q;

  // No spurious interrupt as reset is released
  a_irq_low_after_reset : assert property (@(posedge clk_sys_i)
    $rose(rst_sys_ni) |=> !timer_irq_o);

endmodule

// ==== rtl/demo_soc.sv ====
// demo_soc top; one external bus host, RAM, GPIO and timer behind a base/mask decoder
`timescale 1ns/1ps

module demo_soc #(
  parameter int gpi_width = 8,
  parameter int gpo_width = 16,
  parameter int mem_depth = 16384
) (
  input  logic                           clk_sys_i,
  input  logic                           rst_sys_ni,

  input  logic                           host_req_i,
  input  logic                           host_we_i,
  input  logic [bus_pkg::bus_be_w-1:0]   host_be_i,
  input  logic [bus_pkg::bus_addr_w-1:0] host_addr_i,
  input  logic [bus_pkg::bus_data_w-1:0] host_wdata_i,
  output logic                           host_rvalid_o,
  output logic [bus_pkg::bus_data_w-1:0] host_rdata_o,
  output logic                           host_err_o,

  input  logic [gpi_width-1:0]           gp_i,
  output logic [gpo_width-1:0]           gp_o,
  output logic                           timer_irq_o
);
  import bus_pkg::*;
  import soc_map_pkg::*;

  logic [nr_devices-1:0] dev_req;
  logic                  dev_we;
  logic [bus_be_w-1:0]   dev_be;
  bus_addr_u             dev_addr;
  logic [bus_data_w-1:0] dev_wdata;
  logic [nr_devices-1:0] dev_rvalid;
  logic [bus_data_w-1:0] dev_rdata [nr_devices];

  bus_decoder u_decoder (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_be_i    (host_be_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .dev_req_o    (dev_req),
    .dev_we_o     (dev_we),
    .dev_be_o     (dev_be),
    .dev_addr_o   (dev_addr),
    .dev_wdata_o  (dev_wdata),
    .dev_rvalid_i (dev_rvalid),
    .dev_rdata_i  (dev_rdata)
  );

  ram_1p #(
    .mem_depth(mem_depth)
  ) u_ram (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (dev_req[dev_ram]),
    .we_i      (dev_we),
    .be_i      (dev_be),
    .addr_i    (dev_addr),
    .wdata_i   (dev_wdata),
    .rvalid_o  (dev_rvalid[dev_ram]),
    .rdata_o   (dev_rdata[dev_ram])
  );

  gpio_regs #(
    .gpi_width(gpi_width),
    .gpo_width(gpo_width)
  ) u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (dev_req[dev_gpio]),
    .we_i      (dev_we),
    .be_i      (dev_be),
    .addr_i    (dev_addr),
    .wdata_i   (dev_wdata),
    .rvalid_o  (dev_rvalid[dev_gpio]),
    .rdata_o   (dev_rdata[dev_gpio]),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  timer_regs u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_req[dev_timer]),
    .we_i       (dev_we),
    .be_i       (dev_be),
    .addr_i     (dev_addr),
    .wdata_i    (dev_wdata),
    .rvalid_o   (dev_rvalid[dev_timer]),
    .rdata_o    (dev_rdata[dev_timer]),
    .timer_irq_o(timer_irq_o)
  );

endmodule

// ==== verif/tb_soc_model.svh ====
// Reference model for demo_soc_tb; included inside the testbench module, RAM words exist only once written
`ifndef TB_SOC_MODEL_SVH
`define TB_SOC_MODEL_SVH

  localparam logic [31:0] ram_start   = 32'h0010_0000;
  localparam logic [31:0] gpio_start  = 32'h8000_0000;
  localparam logic [31:0] timer_start = 32'h8000_2000;

  localparam int region_ram   = 0;
  localparam int region_gpio  = 1;
  localparam int region_timer = 2;
  localparam int region_none  = 3;

  logic [31:0] ram_words [logic [13:0]]; // Keyed by word index inside the 64 KiB window
  logic [15:0] gpo_model = '0;

  // 64 KiB RAM, then two 4 KiB register pages
  function automatic int region_of(input logic [31:0] addr);
    if (addr[31:16] == ram_start[31:16]) return region_ram;
    if (addr[31:12] == gpio_start[31:12]) return region_gpio;
    if (addr[31:12] == timer_start[31:12]) return region_timer;
    return region_none;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] lane_mask;
    lane_mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~lane_mask) | (new_word & lane_mask);
  endfunction

  function automatic void ram_model_write(input logic [31:0] addr, input logic [31:0] data,
                                          input logic [3:0] be);
    logic [31:0] old_word;
    old_word = ram_words.exists(addr[15:2]) ? ram_words[addr[15:2]] : 'x;
    ram_words[addr[15:2]] = merge_bytes(old_word, data, be);
  endfunction

  function automatic logic [31:0] ram_model_read(input logic [31:0] addr);
    return ram_words.exists(addr[15:2]) ? ram_words[addr[15:2]] : 'x;
  endfunction

  function automatic void gpo_model_write(input logic [31:0] data, input logic [3:0] be);
    logic [31:0] merged;
    merged = merge_bytes({16'h0, gpo_model}, data, be);
    gpo_model = merged[15:0]; // Only 16 output pins
  endfunction

`endif

// ==== verif/demo_soc_tb.sv ====
// demo_soc testbench; single host, fixed LFSR seed, stops at the first mismatch
`timescale 1ns/1ps

module demo_soc_tb;

  localparam int rsp_timeout  = 4; // Negedges to wait for a response
  localparam int irq_timeout  = 64;
  localparam int ram_ops      = 48;
  localparam int gpio_ops     = 8;
  localparam int unmapped_ops = 8;

  logic        clk_sys;
  logic        rst_sys_n;
  logic        host_req;
  logic        host_we;
  logic [3:0]  host_be;
  logic [31:0] host_addr;
  logic [31:0] host_wdata;
  logic        host_rvalid;
  logic [31:0] host_rdata;
  logic        host_err;
  logic [7:0]  gp_in;
  logic [15:0] gp_out;
  logic        timer_irq;
  logic [31:0] lfsr_state = 32'h0b1c7203;

  `include "tb_soc_model.svh"

  demo_soc #(
    .gpi_width(8),
    .gpo_width(16),
    .mem_depth(16384)
  ) dut0 (
    .clk_sys_i    (clk_sys),
    .rst_sys_ni   (rst_sys_n),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_be_i    (host_be),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata),
    .host_err_o   (host_err),
    .gp_i         (gp_in),
    .gp_o         (gp_out),
    .timer_irq_o  (timer_irq)
  );

  initial begin
    clk_sys = 1'b0;
    forever #50 clk_sys = ~clk_sys;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "demo_soc_tb stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      abort_run($sformatf("CHECK FAILED %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  task automatic wait_response(output int waited);
    waited = 0;
    do begin
      @(negedge clk_sys);
      waited++;
    end while (!host_rvalid && waited < rsp_timeout);
    assert (host_rvalid) else abort_run("no response on host_rvalid_o before the timeout");
  endtask

  // One request, response expected one cycle after it is accepted
  task automatic bus_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    @(posedge clk_sys);
    host_req   <= 1'b1;
    host_we    <= we;
    host_be    <= be;
    host_addr  <= addr;
    host_wdata <= wdata;
    @(posedge clk_sys);
    host_req <= 1'b0;
    wait_response(waited);
    check_eq("response_latency", 1, waited);
    rdata = host_rdata;
    err   = host_err;
    check_eq("error_flag", region_of(addr) == region_none, err);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    logic [31:0] unused_rdata;
    logic        err;
    bus_access(1'b1, be, addr, data, unused_rdata, err);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    logic err;
    bus_access(1'b0, 4'hf, addr, '0, data, err);
  endtask

  // Second request is accepted while the first response returns
  task automatic read_back_to_back(input logic [31:0] addr_a, input logic [31:0] addr_b,
                                   output logic [31:0] data_a, output logic [31:0] data_b);
    int waited;
    @(posedge clk_sys);
    host_req  <= 1'b1;
    host_we   <= 1'b0;
    host_be   <= 4'hf;
    host_addr <= addr_a;
    @(posedge clk_sys);
    host_addr <= addr_b;
    wait_response(waited);
    check_eq("b2b_first_latency", 1, waited);
    data_a = host_rdata;
    @(posedge clk_sys);
    host_req <= 1'b0;
    wait_response(waited);
    check_eq("b2b_second_latency", 1, waited);
    data_b = host_rdata;
    @(negedge clk_sys);
    check_eq("b2b_rvalid_drop", 0, host_rvalid);
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] rdata_b;
    logic [31:0] addr;
    logic [31:0] ram_addr;
    logic [31:0] data;
    logic [31:0] t_lo;
    logic [31:0] t_hi;
    logic [63:0] t0;
    logic [63:0] t1;
    logic [63:0] cmp;
    logic [3:0]  be;
    logic        err;
    logic [31:0] ram_addrs [$];
    int          waited;
    int          tries;

    host_req   <= 1'b0;
    host_we    <= 1'b0;
    host_be    <= '0;
    host_addr  <= '0;
    host_wdata <= '0;
    gp_in      <= '0;
    rst_sys_n  <= 1'b0;
    repeat (16) @(posedge clk_sys);
    rst_sys_n <= 1'b1;
    @(negedge clk_sys);
    check_eq("reset_rvalid", 0, host_rvalid);
    check_eq("reset_err", 0, host_err);
    check_eq("reset_gp_o", 0, gp_out);
    check_eq("reset_irq", 0, timer_irq);

    // Eight fully written RAM words, then random byte traffic on them
    repeat (8) begin
      addr = ram_start | (lfsr_bits(14) << 2);
      data = lfsr_bits(32);
      bus_write(addr, data, 4'hf);
      ram_model_write(addr, data, 4'hf);
      ram_addrs.push_back(addr);
    end
    repeat (ram_ops) begin
      addr = ram_addrs[lfsr_bits(3)];
      if (lfsr_bits(1) != 0) begin
        data = lfsr_bits(32);
        be   = 4'(lfsr_bits(4));
        bus_write(addr, data, be);
        ram_model_write(addr, data, be);
      end else begin
        bus_read(addr, rdata);
        check_eq("ram_read", ram_model_read(addr), rdata);
      end
    end
    read_back_to_back(ram_addrs[0], ram_addrs[1], rdata, rdata_b);
    check_eq("b2b_first_data", ram_model_read(ram_addrs[0]), rdata);
    check_eq("b2b_second_data", ram_model_read(ram_addrs[1]), rdata_b);

    repeat (gpio_ops) begin
      data = lfsr_bits(32);
      be   = 4'(lfsr_bits(4));
      bus_write(gpio_start, data, be);
      gpo_model_write(data, be);
      check_eq("gpio_pins", gpo_model, gp_out);
      bus_read(gpio_start, rdata);
      check_eq("gpio_out_read", {16'h0, gpo_model}, rdata);
      @(posedge clk_sys);
      gp_in <= 8'(lfsr_bits(8));
      repeat (3) @(posedge clk_sys); // Past the two-flop synchronizer
      bus_read(gpio_start + 32'd4, rdata);
      check_eq("gpio_in_read", {24'h0, gp_in}, rdata);
    end

    repeat (unmapped_ops) begin
      ram_addr = ram_addrs[lfsr_bits(3)];
      tries    = 0;
      do begin
        addr = (lfsr_bits(16) << 16) | {16'h0, ram_addr[15:0]}; // Same offset as a RAM word
        tries++;
      end while (region_of(addr) != region_none && tries < 16);
      assert (region_of(addr) == region_none) else begin
        abort_run("the LFSR gave no unmapped address within 16 tries");
      end
      bus_access(1'b0, 4'hf, addr, '0, rdata, err);
      check_eq("unmapped_err", 1, err);
      check_eq("unmapped_rdata", 0, rdata);
      bus_write(addr, lfsr_bits(32), 4'hf);
      bus_write({addr[31:12], 12'h000}, lfsr_bits(32), 4'hf); // Offset of gpio_out_reg
      bus_read(ram_addr, rdata);
      check_eq("ram_after_unmapped", ram_model_read(ram_addr), rdata);
      check_eq("gpio_after_unmapped", gpo_model, gp_out);
    end

    bus_read(timer_start, t_lo);
    bus_read(timer_start + 32'd4, t_hi);
    t0 = {t_hi, t_lo};
    bus_read(timer_start, t_lo);
    bus_read(timer_start + 32'd4, t_hi);
    t1 = {t_hi, t_lo};
    assert (t1 > t0) else begin
      abort_run($sformatf("CHECK FAILED mtime_increasing expected above %0h actual %0h", t0, t1));
    end
    cmp = t1 + 64'd20;
    bus_write(timer_start + 32'd12, cmp[63:32], 4'hf);
    bus_write(timer_start + 32'd8, cmp[31:0], 4'hf);
    check_eq("irq_before_compare", 0, timer_irq);
    waited = 0;
    while (!timer_irq && waited < irq_timeout) begin
      @(negedge clk_sys);
      waited++;
    end
    assert (timer_irq) else abort_run("timer_irq_o did not rise after mtime passed mtimecmp");
    bus_write(timer_start + 32'd12, 32'hffff_ffff, 4'hf);
    waited = 0;
    while (timer_irq && waited < 2) begin
      @(negedge clk_sys);
      waited++;
    end
    assert (!timer_irq) else abort_run("timer_irq_o stayed high after mtimecmp was raised");
    bus_write(timer_start + 32'd8, 32'hffff_ffff, 4'hf);

    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== demo_soc.f ====
+incdir+verif
rtl/bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/bus_decoder.sv
rtl/ram_1p.sv
rtl/gpio_regs.sv
rtl/timer_regs.sv
rtl/demo_soc.sv
verif/demo_soc_tb.sv

// ==== Bender.yml ====
package:
  name: demo_soc

sources:
  - rtl/bus_pkg.sv
  - rtl/soc_map_pkg.sv
  - rtl/bus_decoder.sv
  - rtl/ram_1p.sv
  - rtl/gpio_regs.sv
  - rtl/timer_regs.sv
  - rtl/demo_soc.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/demo_soc_tb.sv
